// ==== rtl/wb_config.svh ====
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// data path width
`define WB_XLEN 32

// exception vector carried by each retiring item
`define EXCP_VEC_WD 15

// exception codes as written to ESTAT.Ecode
`define ECODE_INT  6'h00
`define ECODE_PIL  6'h01
`define ECODE_PIS  6'h02
`define ECODE_PIF  6'h03
`define ECODE_PME  6'h04
`define ECODE_PPI  6'h07
`define ECODE_ADEF 6'h08
`define ECODE_ALE  6'h09
`define ECODE_SYS  6'h0b
`define ECODE_BRK  6'h0c
`define ECODE_INE  6'h0d
`define ECODE_IPE  6'h0e
`define ECODE_TLBR 6'h3f

// implemented csr numbers
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030

`endif

// ==== rtl/wb_pkg.sv ====
`include "wb_config.svh"

package wb_pkg;

    // what the retiring instruction asks of writeback
    typedef enum logic [1:0] {
        kind_normal = 2'd0,
        kind_csr    = 2'd1,
        kind_ertn   = 2'd2
    } wb_kind_t;

    typedef enum logic [1:0] {
        op_rd   = 2'd0,
        op_wr   = 2'd1,
        op_xchg = 2'd2
    } csr_op_t;

    typedef struct packed {
        logic [15:0] rsvd;
        csr_op_t     op;
        logic [13:0] num;
    } csr_ctl_t;

    // result word for normal items, csr control word for csr items
    typedef union packed {
        logic [`WB_XLEN-1:0] data;
        csr_ctl_t            ctl;
    } wb_payload_u;

    typedef struct packed {
        logic [31:0]             pc;
        wb_kind_t                kind;
        wb_payload_u             payload;
        logic [`WB_XLEN-1:0]     csr_wdata;
        logic [`WB_XLEN-1:0]     csr_mask;
        logic [4:0]              dest;
        logic                    gr_we;
        logic [`EXCP_VEC_WD-1:0] excp_vec;
    } ms_item_t;

    typedef struct packed {
        logic                we;
        logic [13:0]         num;
        logic [`WB_XLEN-1:0] wmask;
        logic [`WB_XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic       flag;
        logic [5:0] ecode;
        logic       ertn;
    } excp_t;

    typedef struct packed {
        logic                we;
        logic [4:0]          waddr;
        logic [`WB_XLEN-1:0] wdata;
    } rf_write_t;

    typedef struct packed {
        logic                valid;
        logic                gr_we;
        logic [4:0]          dest;
        logic [`WB_XLEN-1:0] result;
        logic [31:0]         pc;
    } ws_forward_t;

endpackage

// ==== rtl/wb_decode.sv ====
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_decode (
    input  logic             ws_valid,
    input  wb_pkg::ms_item_t ws_item,
    output wb_pkg::csr_req_t csr_req,
    output wb_pkg::excp_t    excp
);

    wb_pkg::csr_ctl_t        ctl;
    logic [`EXCP_VEC_WD-1:0] vec;
    logic                    any_excp;
    logic                    is_csr;
    logic [5:0]              ecode;
    logic [`WB_XLEN-1:0]     eff_mask;

    assign ctl      = ws_item.payload.ctl;
    assign vec      = ws_item.excp_vec;
    assign any_excp = |vec;
    assign is_csr   = (ws_item.kind == wb_pkg::kind_csr);

    // write mask depends on the csr op
    always_comb begin
        case (ctl.op)
            wb_pkg::op_wr:   eff_mask = {`WB_XLEN{1'b1}};
            wb_pkg::op_xchg: eff_mask = ws_item.csr_mask;
            default:         eff_mask = '0;
        endcase
    end

    // lowest vector bit wins
    always_comb begin
        if (vec[0]) begin
            ecode = `ECODE_INT;
        end else if (vec[1]) begin
            ecode = `ECODE_ADEF;
        end else if (vec[2]) begin
            ecode = `ECODE_TLBR;
        end else if (vec[3]) begin
            ecode = `ECODE_PIF;
        end else if (vec[4]) begin
            ecode = `ECODE_PPI;
        end else if (vec[5]) begin
            ecode = `ECODE_SYS;
        end else if (vec[6]) begin
            ecode = `ECODE_BRK;
        end else if (vec[7]) begin
            ecode = `ECODE_INE;
        end else if (vec[8]) begin
            ecode = `ECODE_IPE;
        end else if (vec[9]) begin
            ecode = `ECODE_ALE;
        end else if (vec[10]) begin
            ecode = `ECODE_TLBR;
        end else if (vec[11]) begin
            ecode = `ECODE_PME;
        end else if (vec[12]) begin
            ecode = `ECODE_PPI;
        end else if (vec[13]) begin
            ecode = `ECODE_PIS;
        end else if (vec[14]) begin
            ecode = `ECODE_PIL;
        end else begin
            ecode = 6'd0;
        end
    end

    // rd never writes, the csr file still sees the number for the read
    assign csr_req.we    = ws_valid && is_csr && (ctl.op != wb_pkg::op_rd);
    assign csr_req.num   = ctl.num;
    assign csr_req.wmask = eff_mask;
    assign csr_req.wdata = ws_item.csr_wdata;

    assign excp.flag  = ws_valid && any_excp;
    assign excp.ecode = ws_valid ? ecode : 6'd0;
    assign excp.ertn  = ws_valid && !any_excp && (ws_item.kind == wb_pkg::kind_ertn);

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/100ps
`include "wb_config.svh"

module csr_file (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::csr_req_t csr_req,
    output logic [31:0]      csr_rdata,
    input  wb_pkg::excp_t    excp,
    input  logic [31:0]      pc,
    output logic [31:0]      era,
    output logic [31:0]      eentry
);

    // writable fields per register
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ERA_WMASK    = 32'hffff_ffff;
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;
    localparam logic [31:0] SAVE0_WMASK  = 32'hffff_ffff;

    // ESTAT.Ecode sits at bits 21:16
    localparam int ECODE_LSB = 16;

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era_r;
    logic [31:0] eentry_r;
    logic [31:0] save0;

    // old bits where the mask is clear, new bits where it is set
    function automatic logic [31:0] merge(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [31:0] req_mask,
        input logic [31:0] field_mask
    );
        logic [31:0] m;
        m = req_mask & field_mask;
        return (old_val & ~m) | (new_val & m);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd     <= '0;
            prmd     <= '0;
            estat    <= '0;
            era_r    <= '0;
            eentry_r <= '0;
            save0    <= '0;
        end else if (excp.flag) begin
            // exception entry, the item's own csr write is dropped
            prmd[2:0]                     <= crmd[2:0];
            crmd[2:0]                     <= 3'b000;
            estat[ECODE_LSB +: 6]         <= excp.ecode;
            estat[ECODE_LSB+6 +: 9]       <= 9'd0;
            era_r                         <= pc;
        end else begin
            if (excp.ertn) begin
                // restore plv and ie
                crmd[2:0] <= prmd[2:0];
            end
            if (csr_req.we) begin
                case (csr_req.num)
                    `CSR_CRMD: begin
                        crmd <= merge(crmd, csr_req.wdata, csr_req.wmask, CRMD_WMASK);
                    end
                    `CSR_PRMD: begin
                        prmd <= merge(prmd, csr_req.wdata, csr_req.wmask, PRMD_WMASK);
                    end
                    `CSR_ERA: begin
                        era_r <= merge(era_r, csr_req.wdata, csr_req.wmask, ERA_WMASK);
                    end
                    `CSR_EENTRY: begin
                        eentry_r <= merge(eentry_r, csr_req.wdata, csr_req.wmask,
                                          EENTRY_WMASK);
                    end
                    `CSR_SAVE0: begin
                        save0 <= merge(save0, csr_req.wdata, csr_req.wmask, SAVE0_WMASK);
                    end
                    // ESTAT has nothing writable here
                    default: begin
                    end
                endcase
            end
        end
    end

    // read returns the value before this cycle's update
    always_comb begin
        case (csr_req.num)
            `CSR_CRMD:   csr_rdata = crmd;
            `CSR_PRMD:   csr_rdata = prmd;
            `CSR_ESTAT:  csr_rdata = estat;
            `CSR_ERA:    csr_rdata = era_r;
            `CSR_EENTRY: csr_rdata = eentry_r;
            `CSR_SAVE0:  csr_rdata = save0;
            default:     csr_rdata = 32'd0;
        endcase
    end

    assign era    = era_r;
    assign eentry = eentry_r;

endmodule

// ==== rtl/wb_stage.sv ====
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ms_valid,
    input  wb_pkg::ms_item_t    ms_item,
    output logic                allowin,
    output logic                ws_valid,
    output wb_pkg::ms_item_t    ws_item,
    input  wb_pkg::excp_t       excp,
    input  logic [31:0]         csr_rdata,
    output wb_pkg::rf_write_t   rf_write,
    output wb_pkg::ws_forward_t ws_forward,
    output logic                excp_flush,
    output logic                ertn_flush
);

    logic                ready_go;
    logic [`WB_XLEN-1:0] final_result;

    // writeback never stalls
    assign ready_go = 1'b1;
    assign allowin  = !ws_valid || ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (allowin) begin
            ws_valid <= ms_valid;
        end
    end

    // item register, payload only
    always_ff @(posedge clk) begin
        if (ms_valid && allowin) begin
            ws_item <= ms_item;
        end
    end

    // csr items write back the old csr value
    always_comb begin
        if (ws_item.kind == wb_pkg::kind_csr) begin
            final_result = csr_rdata;
        end else begin
            final_result = ws_item.payload.data;
        end
    end

    assign rf_write.we    = ws_valid && ws_item.gr_we && !excp.flag;
    assign rf_write.waddr = ws_item.dest;
    assign rf_write.wdata = final_result;

    // forward record for decode
    assign ws_forward.valid  = ws_valid;
    assign ws_forward.gr_we  = ws_item.gr_we;
    assign ws_forward.dest   = ws_item.dest;
    assign ws_forward.result = final_result;
    assign ws_forward.pc     = ws_item.pc;

    // strobes already carry the valid gate
    assign excp_flush = excp.flag;
    assign ertn_flush = excp.ertn;

endmodule

// ==== rtl/wb_top.sv ====
`timescale 1ns/100ps

module wb_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                ms_valid,
    input  wb_pkg::ms_item_t    ms_item,
    output logic                allowin,
    output wb_pkg::rf_write_t   rf_write,
    output wb_pkg::ws_forward_t ws_forward,
    output logic                excp_flush,
    output logic                ertn_flush,
    output logic [31:0]         era,
    output logic [31:0]         eentry
);

    logic             ws_valid;
    wb_pkg::ms_item_t ws_item;
    wb_pkg::csr_req_t csr_req;
    wb_pkg::excp_t    excp;
    logic [31:0]      csr_rdata;

    wb_stage u_stage (
        .clk        (clk),
        .reset      (reset),
        .ms_valid   (ms_valid),
        .ms_item    (ms_item),
        .allowin    (allowin),
        .ws_valid   (ws_valid),
        .ws_item    (ws_item),
        .excp       (excp),
        .csr_rdata  (csr_rdata),
        .rf_write   (rf_write),
        .ws_forward (ws_forward),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    wb_decode u_decode (
        .ws_valid (ws_valid),
        .ws_item  (ws_item),
        .csr_req  (csr_req),
        .excp     (excp)
    );

    csr_file u_csr (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .excp      (excp),
        .pc        (ws_item.pc),
        .era       (era),
        .eentry    (eentry)
    );

endmodule

// ==== testbench/wb_assertions.sv ====
`timescale 1ns/100ps

module wb_assertions (
    input  logic              clk,
    input  logic              reset,
    input  logic              allowin,
    input  wb_pkg::rf_write_t rf_write,
    input  logic              excp_flush,
    input  logic              ertn_flush
);

    // one flush kind per retiring item
    flush_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(excp_flush && ertn_flush)
    ) else $error("excp_flush and ertn_flush are high in the same cycle");

    no_write_on_excp: assert property (
        @(posedge clk) disable iff (reset) !(rf_write.we && excp_flush)
    ) else $error("register write enabled while excp_flush is high");

    // writeback never stalls
    allowin_high: assert property (
        @(posedge clk) disable iff (reset) allowin
    ) else $error("allowin is low outside reset");

endmodule

bind wb_top wb_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .allowin    (allowin),
    .rf_write   (rf_write),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush)
);

// ==== testbench/wb_checker.sv ====
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                ms_valid,
    input  wb_pkg::ms_item_t    ms_item,
    input  logic                allowin,
    input  wb_pkg::rf_write_t   rf_write,
    input  wb_pkg::ws_forward_t ws_forward,
    input  logic                excp_flush,
    input  logic                ertn_flush,
    input  logic [31:0]         era,
    input  logic [31:0]         eentry,
    input  int                  test_id,
    output int                  error_count,
    output int                  check_count
);

    // model csrs, a missing entry reads as zero
    logic [31:0]      csr_m [logic [13:0]];
    wb_pkg::ms_item_t held;
    logic             held_valid = 1'b0;
    int               errors = 0;
    int               checks = 0;
    int               cur_test = 0;
    int               errors_at_start = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic logic [31:0] read_csr(input logic [13:0] num);
        return csr_m.exists(num) ? csr_m[num] : 32'd0;
    endfunction

    function automatic logic [31:0] field_mask(input logic [13:0] num);
        case (num)
            `CSR_CRMD:   return 32'h0000_0007;
            `CSR_PRMD:   return 32'h0000_0007;
            `CSR_ERA:    return 32'hffff_ffff;
            `CSR_EENTRY: return 32'hffff_ffc0;
            `CSR_SAVE0:  return 32'hffff_ffff;
            default:     return 32'd0;
        endcase
    endfunction

    function automatic logic [5:0] code_of_bit(input int idx);
        case (idx)
            0:       return `ECODE_INT;
            1:       return `ECODE_ADEF;
            2:       return `ECODE_TLBR;
            3:       return `ECODE_PIF;
            4:       return `ECODE_PPI;
            5:       return `ECODE_SYS;
            6:       return `ECODE_BRK;
            7:       return `ECODE_INE;
            8:       return `ECODE_IPE;
            9:       return `ECODE_ALE;
            10:      return `ECODE_TLBR;
            11:      return `ECODE_PME;
            12:      return `ECODE_PPI;
            13:      return `ECODE_PIS;
            default: return `ECODE_PIL;
        endcase
    endfunction

    // scan from the top so the lowest set bit is left last
    function automatic logic [5:0] priority_ecode(input logic [`EXCP_VEC_WD-1:0] vec);
        logic [5:0] code;
        code = 6'd0;
        for (int i = `EXCP_VEC_WD - 1; i >= 0; i--) begin
            if (vec[i]) code = code_of_bit(i);
        end
        return code;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "normal writeback";
            2:       return "csr access";
            3:       return "exception entry";
            4:       return "ertn return";
            default: return "mixed stream";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_value(what, 32'(got), 32'(exp));
    endtask

    task automatic compare_outputs();
        logic        exc;
        logic [31:0] exp_data;
        exc = |held.excp_vec;
        if (held.kind == wb_pkg::kind_csr) begin
            exp_data = read_csr(held.payload.ctl.num);
        end else begin
            exp_data = held.payload.data;
        end
        check_bit("allowin", allowin, 1'b1);
        check_bit("excp_flush", excp_flush, held_valid && exc);
        check_bit("ertn_flush", ertn_flush,
                  held_valid && !exc && held.kind == wb_pkg::kind_ertn);
        check_bit("rf_write.we", rf_write.we, held_valid && held.gr_we && !exc);
        check_bit("ws_forward.valid", ws_forward.valid, held_valid);
        if (held_valid) begin
            check_bit("ws_forward.gr_we", ws_forward.gr_we, held.gr_we);
            check_value("ws_forward.dest", 32'(ws_forward.dest), 32'(held.dest));
            check_value("ws_forward.result", ws_forward.result, exp_data);
            check_value("ws_forward.pc", ws_forward.pc, held.pc);
            if (rf_write.we) begin
                check_value("rf_write.waddr", 32'(rf_write.waddr), 32'(held.dest));
                check_value("rf_write.wdata", rf_write.wdata, exp_data);
            end
        end
        check_value("era", era, read_csr(`CSR_ERA));
        check_value("eentry", eentry, read_csr(`CSR_EENTRY));
    endtask

    // csr effects of the held item, seen after the next rising edge
    task automatic retire(input wb_pkg::ms_item_t item);
        logic [31:0] crmd;
        logic [31:0] prmd;
        logic [31:0] mask;
        logic [13:0] num;
        crmd = read_csr(`CSR_CRMD);
        prmd = read_csr(`CSR_PRMD);
        num  = item.payload.ctl.num;
        if (|item.excp_vec) begin
            csr_m[`CSR_PRMD]  = {prmd[31:3], crmd[2:0]};
            csr_m[`CSR_CRMD]  = {crmd[31:3], 3'b000};
            csr_m[`CSR_ESTAT] = {10'd0, priority_ecode(item.excp_vec), 16'd0};
            csr_m[`CSR_ERA]   = item.pc;
        end else if (item.kind == wb_pkg::kind_ertn) begin
            csr_m[`CSR_CRMD] = {crmd[31:3], prmd[2:0]};
        end else if (item.kind == wb_pkg::kind_csr &&
                     item.payload.ctl.op != wb_pkg::op_rd) begin
            mask = (item.payload.ctl.op == wb_pkg::op_wr) ? 32'hffff_ffff : item.csr_mask;
            mask = mask & field_mask(num);
            csr_m[num] = (read_csr(num) & ~mask) | (item.csr_wdata & mask);
        end
    endtask

    // mid-cycle, outputs and inputs are both settled
    always @(negedge clk) begin
        if (test_id != cur_test) begin
            if (cur_test != 0) begin
                $display("test %0d %s done, %0d errors", cur_test, test_name(cur_test),
                         errors - errors_at_start);
            end
            cur_test        = test_id;
            errors_at_start = errors;
        end
        if (reset) begin
            held_valid = 1'b0;
            csr_m.delete();
        end else begin
            compare_outputs();
            if (held_valid) retire(held);
            if (ms_valid && allowin) held = ms_item;
            held_valid = ms_valid && allowin;
        end
    end

endmodule

// ==== testbench/wb_tb.sv ====
`timescale 1ns/100ps
`include "wb_config.svh"

module wb_tb;

    localparam int NUM_TESTS      = 5;
    localparam int ITEMS_PER_TEST = 200;
    localparam int CLK_PERIOD     = 10;

    logic                clk;
    logic                reset;
    logic                ms_valid;
    wb_pkg::ms_item_t    ms_item;
    logic                allowin;
    wb_pkg::rf_write_t   rf_write;
    wb_pkg::ws_forward_t ws_forward;
    logic                excp_flush;
    logic                ertn_flush;
    logic [31:0]         era;
    logic [31:0]         eentry;
    int                  test_id;
    int                  error_count;
    int                  check_count;

    wb_top DUT (.*);

    wb_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_TESTS * ITEMS_PER_TEST + 100) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [13:0] pick_csr_num();
        case ($urandom_range(0, 6))
            0:       return `CSR_CRMD;
            1:       return `CSR_PRMD;
            2:       return `CSR_ESTAT;
            3:       return `CSR_ERA;
            4:       return `CSR_EENTRY;
            5:       return `CSR_SAVE0;
            default: return 14'h02a;
        endcase
    endfunction

    function automatic wb_pkg::csr_op_t pick_op();
        case ($urandom_range(0, 2))
            0:       return wb_pkg::op_rd;
            1:       return wb_pkg::op_wr;
            default: return wb_pkg::op_xchg;
        endcase
    endfunction

    function automatic wb_pkg::ms_item_t make_normal();
        wb_pkg::ms_item_t item;
        logic [31:0]      r;
        r = $urandom;
        item.pc           = $urandom & 32'hffff_fffc;
        item.kind         = wb_pkg::kind_normal;
        item.payload.data = $urandom;
        item.csr_wdata    = $urandom;
        item.csr_mask     = $urandom;
        item.dest         = r[4:0];
        item.gr_we        = r[8];
        item.excp_vec     = '0;
        return item;
    endfunction

    // rsvd bits keep the random data word
    function automatic wb_pkg::ms_item_t make_csr(input logic [13:0] num,
                                                   input wb_pkg::csr_op_t op);
        wb_pkg::ms_item_t item;
        item = make_normal();
        item.kind            = wb_pkg::kind_csr;
        item.payload.ctl.num = num;
        item.payload.ctl.op  = op;
        item.gr_we           = 1'b1;
        return item;
    endfunction

    function automatic wb_pkg::ms_item_t make_ertn();
        wb_pkg::ms_item_t item;
        item = make_normal();
        item.kind  = wb_pkg::kind_ertn;
        item.gr_we = 1'b0;
        return item;
    endfunction

    function automatic wb_pkg::ms_item_t make_excp();
        wb_pkg::ms_item_t item;
        logic [31:0]      v;
        case ($urandom_range(0, 2))
            0:       item = make_normal();
            1:       item = make_csr(pick_csr_num(), pick_op());
            default: item = make_ertn();
        endcase
        // always leaves at least one bit inside the vector
        v = ($urandom | 32'd1) << $urandom_range(0, 14);
        item.excp_vec = v[14:0];
        return item;
    endfunction

    function automatic wb_pkg::ms_item_t make_any();
        case ($urandom_range(0, 9))
            0, 1, 2, 3: return make_normal();
            4, 5, 6:    return make_csr(pick_csr_num(), pick_op());
            7:          return make_excp();
            default:    return make_ertn();
        endcase
    endfunction

    task automatic send_item(input wb_pkg::ms_item_t item);
        ms_valid = 1'b1;
        ms_item  = item;
        @(negedge clk);
        while (!allowin) @(negedge clk);
        @(posedge clk);
        #1;
        ms_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        ms_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(32'hc571));
        reset    = 1'b1;
        ms_valid = 1'b0;
        ms_item  = '0;
        test_id  = 0;
        repeat (10) @(posedge clk);
        #1;
        reset   = 1'b0;

        test_id = 1;
        for (int i = 0; i < ITEMS_PER_TEST; i++) begin
            if ($urandom_range(0, 3) == 0) idle_cycle();
            else send_item(make_normal());
        end
        repeat (2) idle_cycle();

        test_id = 2;
        for (int i = 0; i < ITEMS_PER_TEST; i++) begin
            send_item(make_csr(pick_csr_num(), pick_op()));
        end
        repeat (2) idle_cycle();

        // set plv and ie, trap, then read back what was saved
        test_id = 3;
        for (int i = 0; i < ITEMS_PER_TEST; i++) begin
            case (i % 5)
                0:       send_item(make_csr(`CSR_CRMD, wb_pkg::op_wr));
                1:       send_item(make_excp());
                2:       send_item(make_csr(`CSR_ESTAT, wb_pkg::op_rd));
                3:       send_item(make_csr(`CSR_ERA, wb_pkg::op_rd));
                default: send_item(make_csr(`CSR_PRMD, wb_pkg::op_rd));
            endcase
        end
        repeat (2) idle_cycle();

        test_id = 4;
        for (int i = 0; i < ITEMS_PER_TEST; i++) begin
            case (i % 3)
                0:       send_item(make_csr(`CSR_PRMD, wb_pkg::op_wr));
                1:       send_item(make_ertn());
                default: send_item(make_csr(`CSR_CRMD, wb_pkg::op_rd));
            endcase
        end
        repeat (2) idle_cycle();

        test_id = 5;
        for (int i = 0; i < ITEMS_PER_TEST; i++) begin
            if ($urandom_range(0, 2) == 0) idle_cycle();
            else send_item(make_any());
        end
        repeat (2) idle_cycle();

        // lets the checker close the last test
        test_id = 6;
        repeat (2) idle_cycle();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_decode.sv
rtl/csr_file.sv
rtl/wb_stage.sv
rtl/wb_top.sv
testbench/wb_assertions.sv
testbench/wb_checker.sv
testbench/wb_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module wb_tb -f tb.f

status=0
./obj_dir/Vwb_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
